//--- tb.f
+incdir+tb
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/regfile.sv
rtl/forward.sv
rtl/alu.sv
rtl/dual_exec_core.sv
tb/dual_exec_tb.sv

//--- Bender.yml
package:
  name: dual_exec_core

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/pipe_pkg.sv
      - rtl/regfile.sv
      - rtl/forward.sv
      - rtl/alu.sv
      - rtl/dual_exec_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/dual_exec_tb.sv

//--- tb/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// architectural state in program order, eu0 before eu1 within a pair
logic [xlen-1:0] model_regs [nregs];
wb_t             exp_q0 [$];
wb_t             exp_q1 [$];

function automatic logic [xlen-1:0] expected_alu(alu_op_e op, logic [xlen-1:0] a,
                                                 logic [xlen-1:0] b);
    logic [xlen-1:0] r;
    case (op)
        alu_add:  r = a + b;
        alu_sub:  r = a + ~b + 1'b1;
        alu_and:  r = a & b;
        alu_or:   r = a | b;
        alu_xor:  r = a ^ b;
        alu_nor:  r = ~a & ~b;
        alu_slt:  r = (a[xlen-1] != b[xlen-1]) ? xlen'(a[xlen-1]) : xlen'(a < b); // sign decides
        alu_sltu: r = xlen'(a < b);
        default:  r = '0;
    endcase
    return r;
endfunction

function automatic wb_t model_exec(instr_t in);
    wb_t w;
    w.valid = in.valid;
    w.rd    = in.rd;
    w.data  = expected_alu(in.op, model_regs[in.rj], model_regs[in.rk]);
    if (in.valid && in.rd != '0) model_regs[in.rd] = w.data; // r0 stays zero
    return w;
endfunction

// two-deep delay line, head comes out when the pair reaches wb
task automatic expect_pair(instr_t i0, instr_t i1, output wb_t e0, output wb_t e1);
    exp_q0.push_back(model_exec(i0));
    exp_q1.push_back(model_exec(i1));
    e0 = exp_q0.pop_front();
    e1 = exp_q1.pop_front();
endtask

task automatic model_reset();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
    exp_q0 = {};
    exp_q1 = {};
    repeat (2) begin
        exp_q0.push_back('0);
        exp_q1.push_back('0);
    end
endtask

`endif

//--- tb/dual_exec_tb.sv
module dual_exec_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    logic   clk;
    logic   rst_n;
    instr_t issue0;
    instr_t issue1;
    wb_t    wb0;
    wb_t    wb1;

    wb_t  exp0; // expected wb lined up with the DUT outputs
    wb_t  exp1;
    logic in_reset_q;
    int   n_issued;
    int   n_wb;

    `include "ref_model.svh"

    dual_exec_core u_dual_exec_core (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue0 (issue0),
        .issue1 (issue1),
        .wb0    (wb0),
        .wb1    (wb1)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        in_reset_q <= !rst_n;
        if (rst_n) n_wb <= n_wb + int'(wb0.valid) + int'(wb1.valid);
    end

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic report_mismatch(string port, wb_t got, wb_t want);
        stop_with_failure($sformatf(
            "error at %0t: %s valid %b rd %0d data %h, expected valid %b rd %0d data %h",
            $time, port, got.valid, got.rd, got.data, want.valid, want.rd, want.data));
    endtask

    a_idle_in_reset: assert property (@(posedge clk) in_reset_q |-> !wb0.valid && !wb1.valid)
        else stop_with_failure($sformatf("error at %0t: wb valid set during reset", $time));
    a_wb0_valid: assert property (@(posedge clk) disable iff (!rst_n) wb0.valid == exp0.valid)
        else report_mismatch("wb0", $sampled(wb0), $sampled(exp0));
    a_wb1_valid: assert property (@(posedge clk) disable iff (!rst_n) wb1.valid == exp1.valid)
        else report_mismatch("wb1", $sampled(wb1), $sampled(exp1));
    a_wb0_data: assert property (@(posedge clk) disable iff (!rst_n)
        exp0.valid |-> wb0.rd == exp0.rd && wb0.data == exp0.data)
        else report_mismatch("wb0", $sampled(wb0), $sampled(exp0));
    a_wb1_data: assert property (@(posedge clk) disable iff (!rst_n)
        exp1.valid |-> wb1.rd == exp1.rd && wb1.data == exp1.data)
        else report_mismatch("wb1", $sampled(wb1), $sampled(exp1));

    function automatic instr_t make_instr(alu_op_e op, int rd, int rj, int rk);
        instr_t in;
        in.valid = 1'b1;
        in.op    = op;
        in.rd    = reg_idx_t'(rd);
        in.rj    = reg_idx_t'(rj);
        in.rk    = reg_idx_t'(rk);
        return in;
    endfunction

    // one pair per rising edge with its expected records
    task automatic issue_pair(instr_t i0, instr_t i1);
        wb_t e0;
        wb_t e1;
        @(posedge clk);
        expect_pair(i0, i1, e0, e1);
        issue0 <= i0;
        issue1 <= i1;
        exp0   <= e0;
        exp1   <= e1;
        n_issued += int'(i0.valid) + int'(i1.valid);
    endtask

    function automatic instr_t random_instr();
        instr_t in;
        in = make_instr(alu_op_e'($urandom_range(7)), $urandom_range(6),
                        $urandom_range(6), $urandom_range(6)); // few regs so hazards are frequent
        in.valid = ($urandom_range(3) != 0);
        return in;
    endfunction

    task automatic random_pair();
        instr_t i0;
        instr_t i1;
        i0 = random_instr();
        i1 = random_instr();
        if (i0.rd != '0) begin
            if (i1.rj == i0.rd) i1.rj = i0.rd ^ 5'd1;
            if (i1.rk == i0.rd) i1.rk = i0.rd ^ 5'd1;
        end
        issue_pair(i0, i1);
    endtask

    // producer pair and d-1 bubbles before a pair reading both results
    task automatic distance_case(int d, int rd);
        issue_pair(make_instr(alu_add, rd, 6, 2), make_instr(alu_sub, rd + 1, 3, 5));
        repeat (d - 1) issue_pair('0, '0);
        issue_pair(make_instr(alu_sub, rd + 2, rd, rd + 1),
                   make_instr(alu_xor, rd + 3, rd + 1, rd));
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (n_wb != n_issued && waited < 20) begin
            issue_pair('0, '0);
            waited++;
        end
    endtask

    initial begin
        void'($urandom(77327));
        clk        = 1'b0;
        rst_n      = 1'b0;
        issue0     = '0;
        issue1     = '0;
        exp0       = '0;
        exp1       = '0;
        in_reset_q = 1'b0;
        n_issued   = 0;
        n_wb       = 0;
        model_reset();
        repeat (4) issue_pair('0, '0);
        rst_n <= 1'b1;

        // every register read once right after reset
        for (int r = 0; r < nregs; r += 2) begin
            issue_pair(make_instr(alu_add, r, r, 0), make_instr(alu_add, r + 1, r + 1, 0));
        end

        issue_pair(make_instr(alu_nor, 1, 0, 0), '0);  // r1 all ones
        issue_pair(make_instr(alu_sltu, 2, 0, 1), '0); // r2 = 1
        issue_pair(make_instr(alu_add, 3, 2, 2), make_instr(alu_sub, 4, 0, 1));
        issue_pair(make_instr(alu_add, 5, 3, 1), make_instr(alu_xor, 6, 1, 2));
        issue_pair(make_instr(alu_add, 7, 1, 6), make_instr(alu_sub, 8, 2, 1));
        issue_pair(make_instr(alu_and, 9, 6, 3), make_instr(alu_or, 10, 3, 2));
        issue_pair(make_instr(alu_xor, 11, 6, 1), make_instr(alu_nor, 12, 2, 3));
        issue_pair(make_instr(alu_slt, 13, 1, 2), make_instr(alu_sltu, 14, 1, 2));
        issue_pair(make_instr(alu_slt, 15, 2, 1), make_instr(alu_sltu, 16, 2, 1));

        distance_case(1, 20);
        distance_case(2, 24);
        distance_case(3, 28);

        // same rd from both units of one pair
        issue_pair(make_instr(alu_add, 17, 1, 1), make_instr(alu_sub, 17, 2, 6));
        issue_pair(make_instr(alu_or, 18, 17, 0), '0);
        issue_pair('0, make_instr(alu_add, 19, 17, 0));
        issue_pair(make_instr(alu_xor, 18, 17, 1), '0);

        // older write in exe2 eu1 and younger in exe1 eu0
        issue_pair('0, make_instr(alu_add, 19, 2, 2));
        issue_pair(make_instr(alu_sub, 19, 0, 1), '0);
        issue_pair(make_instr(alu_add, 16, 19, 19), make_instr(alu_or, 15, 0, 19));
        issue_pair('0, '0);
        issue_pair(make_instr(alu_and, 16, 19, 1), '0);

        issue_pair(make_instr(alu_nor, 0, 0, 0), make_instr(alu_xor, 0, 1, 2));
        issue_pair(make_instr(alu_add, 21, 0, 0), make_instr(alu_or, 22, 0, 1));
        issue_pair('0, '0);
        issue_pair(make_instr(alu_sub, 23, 0, 1), make_instr(alu_add, 24, 0, 0));

        repeat (5) issue_pair('0, '0);
        repeat (400) random_pair();
        drain_pipeline();

        if (n_wb == n_issued) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_with_failure("timeout: not every issued instruction reached writeback");
        end
    end

endmodule

//--- rtl/dual_exec_core.sv
module dual_exec_core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t issue0, // older of the pair
    input  instr_t issue1,
    output wb_t    wb0,
    output wb_t    wb1
);

    logic [xlen-1:0] rf_eu0_rj;
    logic [xlen-1:0] rf_eu0_rk;
    logic [xlen-1:0] rf_eu1_rj;
    logic [xlen-1:0] rf_eu1_rk;

    logic [xlen-1:0] eu0_src0;
    logic [xlen-1:0] eu0_src1;
    logic [xlen-1:0] eu1_src0;
    logic [xlen-1:0] eu1_src1;

    ex_entry_t ex1_q0;
    ex_entry_t ex1_q1;
    wb_t       ex2_q0;
    wb_t       ex2_q1;

    logic [xlen-1:0] alu_res0;
    logic [xlen-1:0] alu_res1;

    fwd_src_t ex1_fwd0;
    fwd_src_t ex1_fwd1;
    fwd_src_t ex2_fwd0;
    fwd_src_t ex2_fwd1;

    // r0 results never bypass
    function automatic fwd_src_t mk_fwd(logic valid, reg_idx_t rd, logic [xlen-1:0] data);
        fwd_src_t f;
        f.en   = valid && (rd != '0);
        f.rd   = rd;
        f.data = data;
        return f;
    endfunction

    regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr0 (issue0.rj),
        .raddr1 (issue0.rk),
        .raddr2 (issue1.rj),
        .raddr3 (issue1.rk),
        .rdata0 (rf_eu0_rj),
        .rdata1 (rf_eu0_rk),
        .rdata2 (rf_eu1_rj),
        .rdata3 (rf_eu1_rk),
        .wr0    (ex2_q0),
        .wr1    (ex2_q1)
    );

    assign ex1_fwd0 = mk_fwd(ex1_q0.valid, ex1_q0.rd, alu_res0);
    assign ex1_fwd1 = mk_fwd(ex1_q1.valid, ex1_q1.rd, alu_res1);
    assign ex2_fwd0 = mk_fwd(ex2_q0.valid, ex2_q0.rd, ex2_q0.data);
    assign ex2_fwd1 = mk_fwd(ex2_q1.valid, ex2_q1.rd, ex2_q1.data);

    forward u_forward (
        .eu0_rj   (issue0.rj),
        .eu0_rk   (issue0.rk),
        .eu1_rj   (issue1.rj),
        .eu1_rk   (issue1.rk),
        .rf00     (rf_eu0_rj),
        .rf01     (rf_eu0_rk),
        .rf10     (rf_eu1_rj),
        .rf11     (rf_eu1_rk),
        .ex1_fwd0 (ex1_fwd0),
        .ex1_fwd1 (ex1_fwd1),
        .ex2_fwd0 (ex2_fwd0),
        .ex2_fwd1 (ex2_fwd1),
        .eu0_src0 (eu0_src0),
        .eu0_src1 (eu0_src1),
        .eu1_src0 (eu1_src0),
        .eu1_src1 (eu1_src1)
    );

    // rf -> exe1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex1_q0.valid <= 1'b0;
            ex1_q1.valid <= 1'b0;
        end else begin
            ex1_q0 <= '{valid: issue0.valid, op: issue0.op, rd: issue0.rd,
                        src0: eu0_src0, src1: eu0_src1};
            ex1_q1 <= '{valid: issue1.valid, op: issue1.op, rd: issue1.rd,
                        src0: eu1_src0, src1: eu1_src1};
        end
    end

    alu u_alu0 (
        .op     (ex1_q0.op),
        .a      (ex1_q0.src0),
        .b      (ex1_q0.src1),
        .result (alu_res0)
    );

    alu u_alu1 (
        .op     (ex1_q1.op),
        .a      (ex1_q1.src0),
        .b      (ex1_q1.src1),
        .result (alu_res1)
    );

    // exe1 -> exe2
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex2_q0.valid <= 1'b0;
            ex2_q1.valid <= 1'b0;
        end else begin
            ex2_q0 <= '{valid: ex1_q0.valid, rd: ex1_q0.rd, data: alu_res0};
            ex2_q1 <= '{valid: ex1_q1.valid, rd: ex1_q1.rd, data: alu_res1};
        end
    end

    assign wb0 = ex2_q0;
    assign wb1 = ex2_q1;

    // issuer splits pairs with an intra-pair dependence
    a_no_pair_dep: assert property (@(posedge clk) disable iff (!rst_n)
        issue0.valid && issue1.valid && (issue0.rd != '0)
        |-> (issue1.rj != issue0.rd) && (issue1.rk != issue0.rd))
        else $error("eu1 reads eu0 rd within one pair");

    // first cycle out of reset still drains the cleared exe1 stage
    a_wb_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |=> !wb0.valid && !wb1.valid)
        else $error("wb valid set right after reset");

endmodule

//--- rtl/alu.sv
module alu
    import isa_pkg::*;
(
    input  alu_op_e         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result
);

    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b; // wraps
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_nor: begin
                result = ~(a | b);
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, lt_s};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, lt_u};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- rtl/forward.sv
module forward
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  reg_idx_t        eu0_rj,
    input  reg_idx_t        eu0_rk,
    input  reg_idx_t        eu1_rj,
    input  reg_idx_t        eu1_rk,
    input  logic [xlen-1:0] rf00,
    input  logic [xlen-1:0] rf01,
    input  logic [xlen-1:0] rf10,
    input  logic [xlen-1:0] rf11,
    input  fwd_src_t        ex1_fwd0,
    input  fwd_src_t        ex1_fwd1,
    input  fwd_src_t        ex2_fwd0,
    input  fwd_src_t        ex2_fwd1,
    output logic [xlen-1:0] eu0_src0,
    output logic [xlen-1:0] eu0_src1,
    output logic [xlen-1:0] eu1_src0,
    output logic [xlen-1:0] eu1_src1
);

    function automatic logic hit(fwd_src_t src, reg_idx_t idx);
        return src.en && (src.rd == idx);
    endfunction

    // youngest first: exe1 eu1, exe1 eu0, exe2 eu1, exe2 eu0, then rf
    function automatic logic [xlen-1:0] pick(
        reg_idx_t        idx,
        logic [xlen-1:0] rf_val,
        fwd_src_t        y1,
        fwd_src_t        y0,
        fwd_src_t        o1,
        fwd_src_t        o0
    );
        logic [xlen-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (hit(y1, idx)) begin
            val = y1.data;
        end else if (hit(y0, idx)) begin
            val = y0.data;
        end else if (hit(o1, idx)) begin
            val = o1.data;
        end else if (hit(o0, idx)) begin
            val = o0.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign eu0_src0 = pick(eu0_rj, rf00, ex1_fwd1, ex1_fwd0, ex2_fwd1, ex2_fwd0);
    assign eu0_src1 = pick(eu0_rk, rf01, ex1_fwd1, ex1_fwd0, ex2_fwd1, ex2_fwd0);
    assign eu1_src0 = pick(eu1_rj, rf10, ex1_fwd1, ex1_fwd0, ex2_fwd1, ex2_fwd0);
    assign eu1_src1 = pick(eu1_rk, rf11, ex1_fwd1, ex1_fwd0, ex2_fwd1, ex2_fwd0);

endmodule

//--- rtl/regfile.sv
module regfile
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  reg_idx_t        raddr0,
    input  reg_idx_t        raddr1,
    input  reg_idx_t        raddr2,
    input  reg_idx_t        raddr3,
    output logic [xlen-1:0] rdata0,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2,
    output logic [xlen-1:0] rdata3,
    input  wb_t             wr0,
    input  wb_t             wr1
);

    logic [xlen-1:0] regs [nregs];

    logic we0;
    logic we1;

    assign we0 = wr0.valid && (wr0.rd != '0);
    assign we1 = wr1.valid && (wr1.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0) regs[wr0.rd] <= wr0.data;
            if (we1) regs[wr1.rd] <= wr1.data; // later write wins on same rd
        end
    end

    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
    assign rdata3 = regs[raddr3];

    // r0 is never written so it keeps its reset value
    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("register 0 is nonzero");

endmodule

//--- rtl/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    // result that can be bypassed to the rf stage
    typedef struct packed {
        logic             en;   // valid and rd nonzero
        reg_idx_t         rd;
        logic [xlen-1:0]  data;
    } fwd_src_t;

    // exe1 stage register contents
    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        reg_idx_t         rd;
        logic [xlen-1:0]  src0;
        logic [xlen-1:0]  src1;
    } ex_entry_t;

    // exe2 stage record, also the writeback port
    typedef struct packed {
        logic             valid;
        reg_idx_t         rd;
        logic [xlen-1:0]  data;
    } wb_t;

endpackage

//--- rtl/isa_pkg.sv
package isa_pkg;

    localparam int xlen  = 32;
    localparam int nregs = 32;

    typedef logic [$clog2(nregs)-1:0] reg_idx_t;

    // register-register alu ops only
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_nor  = 3'd5,
        alu_slt  = 3'd6, // signed
        alu_sltu = 3'd7  // unsigned
    } alu_op_e;

    // one slot of an issued pair
    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
    } instr_t;

endpackage
